/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_pm
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
pm_state_pkg.sv
pm_instr_pkg.sv
pm_cycle.sv
pm_decode.sv
pm_seq.sv
pm_strobe.sv
pm_top.sv
tb_clock.sv
tb_pm.sv

/* pm_cycle.sv */
// front panel START/WAIT flags and the KC/PC machine cycle timer, instantiated once in pm_top
`timescale 1ns/1ns

module pm_cycle #(
	parameter int KC_TICKS = 3,
	parameter int PC_TICKS = 2
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic start_sw,
	input  logic stop_sw,
	input  logic hlt,
	output logic run,
	output logic cycle_end
);

	localparam int MAX_TICKS = (KC_TICKS > PC_TICKS) ? KC_TICKS : PC_TICKS;
	localparam int CNT_W = $clog2(MAX_TICKS + 1);

	logic start_sw_q;
	logic start_q;
	logic wait_q;
	logic start_d;
	logic wait_d;
	logic run_d;
	logic active_q;
	logic in_pc_q;
	logic [CNT_W-1:0] cnt_q;
	logic cycle_end_q;

	// next flag values, stop clears both
	always_comb begin
		start_d = start_q;
		wait_d = wait_q;
		if (stop_sw) begin
			start_d = 1'b0;
			wait_d = 1'b0;
		end else begin
			if (start_sw && !start_sw_q)
				start_d = 1'b1;
			// halt only lands on a cycle boundary
			if (cycle_end_q && hlt)
				wait_d = 1'b1;
		end
		run_d = start_d && !wait_d;
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			start_sw_q <= 1'b0;
			start_q <= 1'b0;
			wait_q <= 1'b0;
		end else begin
			start_sw_q <= start_sw;
			start_q <= start_d;
			wait_q <= wait_d;
		end
	end

	// down-counter plays KC then PC
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			in_pc_q <= 1'b0;
			cnt_q <= '0;
			cycle_end_q <= 1'b0;
		end else begin
			cycle_end_q <= 1'b0;
			if (!active_q) begin
				if (run_d) begin
					active_q <= 1'b1;
					in_pc_q <= 1'b0;
					cnt_q <= CNT_W'(KC_TICKS - 1);
				end
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end else if (!in_pc_q) begin
				// KC expiry closes the cycle, timer idles if the machine is stopping
				cycle_end_q <= 1'b1;
				in_pc_q <= 1'b1;
				cnt_q <= CNT_W'(PC_TICKS - 1);
				active_q <= run_d;
			end else begin
				in_pc_q <= 1'b0;
				cnt_q <= CNT_W'(KC_TICKS - 1);
			end
		end
	end

	assign run = start_q && !wait_q;
	assign cycle_end = cycle_end_q;

	// a pulse with run low is the last one before the timer goes idle
	a_final_cycle_end: assert property (@(posedge __clk) disable iff (!rst_n)
		cycle_end && !run |-> !active_q);

endmodule

/* pm_decode.sv */
// instruction decoder that latches the fetched word fields for the sequencer and strobe stages
`timescale 1ns/1ns

module pm_decode
	import pm_state_pkg::*, pm_instr_pkg::*;
(
	input  logic __clk,
	input  logic rst_n,
	input  logic cycle_end,
	input  pm_state_t state,
	input  logic [WORD_W-1:0] rdt,
	output logic need_arg,
	output logic need_bmod,
	output logic need_ind,
	output logic [STEP_W-1:0] steps,
	output logic [FIELD_W-1:0] a_field,
	output logic [FIELD_W-1:0] b_field
);

	logic fetch;
	logic arg_now;
	logic bmod_now;
	logic ind_now;
	logic [STEP_W-1:0] steps_now;
	logic arg_q;
	logic bmod_q;
	logic ind_q;
	logic [STEP_W-1:0] steps_q;
	logic [FIELD_W-1:0] a_q;
	logic [FIELD_W-1:0] b_q;

	// rdt is valid for the whole of P1
	assign fetch = (state == P1);

	assign arg_now = (rdt[c_lsb +: FIELD_W] == '0);
	assign bmod_now = (rdt[b_lsb +: FIELD_W] != '0);
	assign ind_now = rdt[d_bit];
	assign steps_now = exec_steps(rdt);

	// held until the next fetch
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			arg_q <= 1'b0;
			bmod_q <= 1'b0;
			ind_q <= 1'b0;
			steps_q <= '0;
			a_q <= '0;
			b_q <= '0;
		end else if (fetch && cycle_end) begin
			arg_q <= arg_now;
			bmod_q <= bmod_now;
			ind_q <= ind_now;
			steps_q <= steps_now;
			a_q <= rdt[a_lsb +: FIELD_W];
			b_q <= rdt[b_lsb +: FIELD_W];
		end
	end

	// P1 picks its successor from the live word, later states from the latch
	assign need_arg = fetch ? arg_now : arg_q;
	assign need_bmod = fetch ? bmod_now : bmod_q;
	assign need_ind = fetch ? ind_now : ind_q;
	assign steps = fetch ? steps_now : steps_q;
	assign a_field = a_q;
	assign b_field = b_q;

endmodule

/* pm_instr_pkg.sv */
// instruction word layout and the execute step rule, shared by the decoder and the reference model
package pm_instr_pkg;

	import pm_state_pkg::*;

	localparam int WORD_W = 16;

	// opcode is six bits, register and modifier fields are three
	localparam int OP_W = 6;
	localparam int FIELD_W = 3;
	localparam int REG_SEL_W = FIELD_W;

	// field positions inside the word
	localparam int op_lsb = 10;
	localparam int d_bit = 9;
	localparam int a_lsb = 6;
	localparam int b_lsb = 3;
	localparam int c_lsb = 0;

	// low two opcode bits plus one, so every instruction runs 1 to 4 execute cycles
	function automatic logic [STEP_W-1:0] exec_steps(input logic [WORD_W-1:0] word);
		logic [OP_W-1:0] op;
		op = word[op_lsb +: OP_W];
		return STEP_W'(op[1:0]) + STEP_W'(1);
	endfunction

endpackage

/* pm_seq.sv */
// main loop sequencer stepping P0..P5 and PP at each cycle end, with interrupt accept and step count
`timescale 1ns/1ns

module pm_seq
	import pm_state_pkg::*;
(
	input  logic __clk,
	input  logic rst_n,
	input  logic run,
	input  logic cycle_end,
	input  logic irq,
	input  logic need_arg,
	input  logic need_bmod,
	input  logic need_ind,
	input  logic [STEP_W-1:0] steps,
	output pm_state_t state,
	output logic last_step,
	output logic mem_rd
);

	pm_state_t state_q;
	pm_state_t state_d;
	pm_state_t after_p1;
	pm_state_t after_p2;
	pm_state_t after_p3;
	logic [STEP_W-1:0] step_q;

	// argument, B-modification and indirect phases are each skipped when not needed
	assign after_p3 = need_ind ? P4 : P5;
	assign after_p2 = need_bmod ? P3 : after_p3;
	assign after_p1 = need_arg ? P2 : after_p2;

	assign last_step = (step_q == STEP_LAST);

	always_comb begin
		state_d = state_q;
		if (cycle_end) begin
			if (!run) begin
				state_d = P0;
			end else begin
				case (state_q)
					P0: state_d = P1;
					P1: state_d = after_p1;
					P2: state_d = after_p2;
					P3: state_d = after_p3;
					P4: state_d = P5;
					// irq only matters once the instruction is done
					P5: begin
						if (last_step)
							state_d = irq ? PP : P1;
					end
					PP: state_d = P1;
					default: state_d = P0;
				endcase
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (!rst_n)
			state_q <= P0;
		else
			state_q <= state_d;
	end

	// load on entry to P5, count down while staying
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			step_q <= '0;
		end else if (state_d == P5) begin
			if (state_q != P5)
				step_q <= steps;
			else if (cycle_end)
				step_q <= step_q - 1'b1;
		end
	end

	assign state = state_q;
	assign mem_rd = reads_memory(state_q);

	a_state_legal: assert property (@(posedge __clk) disable iff (!rst_n)
		state_q inside {P0, P1, P2, P3, P4, P5, PP});

	// step count loaded from decode must never be zero in execute
	a_steps_in_p5: assert property (@(posedge __clk) disable iff (!rst_n)
		state_q == P5 |-> step_q != '0);

endmodule

/* pm_state_pkg.sv */
// sequencer state encoding and step constants, imported by the control unit stages and the model
package pm_state_pkg;

	localparam int STATE_W = 3;

	// execute step counter, wide enough for four steps
	localparam int STEP_W = 3;

	// main loop states, P0 means the machine is stopped
	typedef enum logic [STATE_W-1:0] {
		P0 = 3'd0,
		P1 = 3'd1,
		P2 = 3'd2,
		P3 = 3'd3,
		P4 = 3'd4,
		P5 = 3'd5,
		PP = 3'd6
	} pm_state_t;

	// counter value during the final execute cycle
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(1);

	// fetch and argument fetch keep a memory read open for the whole cycle
	function automatic logic reads_memory(input pm_state_t s);
		return (s == P1) || (s == P2);
	endfunction

endpackage

/* pm_strobe.sv */
// bus strobe generator, one registered pulse per finished state plus the register selector
`timescale 1ns/1ns

module pm_strobe
	import pm_state_pkg::*, pm_instr_pkg::*;
(
	input  logic __clk,
	input  logic rst_n,
	input  logic cycle_end,
	input  pm_state_t state,
	input  logic last_step,
	input  logic [FIELD_W-1:0] a_field,
	input  logic [FIELD_W-1:0] b_field,
	output logic w_ir,
	output logic w_ac,
	output logic w_r,
	output logic w_ic,
	output logic ic_inc,
	output logic [REG_SEL_W-1:0] reg_sel
);

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			w_ir <= 1'b0;
			w_ac <= 1'b0;
			w_r <= 1'b0;
			w_ic <= 1'b0;
			ic_inc <= 1'b0;
			reg_sel <= '0;
		end else begin
			w_ir <= 1'b0;
			w_ac <= 1'b0;
			w_r <= 1'b0;
			w_ic <= 1'b0;
			ic_inc <= 1'b0;
			// strobes describe the state that is just ending
			if (cycle_end) begin
				case (state)
					P1: begin
						w_ir <= 1'b1;
						ic_inc <= 1'b1;
					end
					P2: begin
						w_ac <= 1'b1;
						ic_inc <= 1'b1;
					end
					P3: begin
						w_ac <= 1'b1;
						reg_sel <= b_field;
					end
					P4: w_ac <= 1'b1;
					// result write only after the last execute cycle
					P5: begin
						if (last_step) begin
							w_r <= 1'b1;
							reg_sel <= a_field;
						end
					end
					PP: w_ic <= 1'b1;
					default: begin
					end
				endcase
			end
		end
	end

	// W bus has a single writer per clock
	a_one_bus_write: assert property (@(posedge __clk) disable iff (!rst_n)
		$onehot0({w_ir, w_ac, w_r, w_ic}));

endmodule

/* pm_top.sv */
// control unit top level: cycle timer, decoder, sequencer and strobes in a chain
`timescale 1ns/1ns

module pm_top
	import pm_state_pkg::*, pm_instr_pkg::*;
#(
	parameter int KC_TICKS = 3,
	parameter int PC_TICKS = 2
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic start_sw,
	input  logic stop_sw,
	input  logic hlt,
	input  logic irq,
	input  logic [WORD_W-1:0] rdt,
	output logic run,
	output pm_state_t state,
	output logic cycle_end,
	output logic mem_rd,
	output logic w_ir,
	output logic w_ac,
	output logic w_r,
	output logic w_ic,
	output logic ic_inc,
	output logic [REG_SEL_W-1:0] reg_sel
);

	logic need_arg;
	logic need_bmod;
	logic need_ind;
	logic [STEP_W-1:0] steps;
	logic [FIELD_W-1:0] a_field;
	logic [FIELD_W-1:0] b_field;
	logic last_step;

	pm_cycle #(
		.KC_TICKS(KC_TICKS),
		.PC_TICKS(PC_TICKS)
	) u_cycle (
		.__clk(__clk),
		.rst_n(rst_n),
		.start_sw(start_sw),
		.stop_sw(stop_sw),
		.hlt(hlt),
		.run(run),
		.cycle_end(cycle_end)
	);

	pm_decode u_decode (
		.__clk(__clk),
		.rst_n(rst_n),
		.cycle_end(cycle_end),
		.state(state),
		.rdt(rdt),
		.need_arg(need_arg),
		.need_bmod(need_bmod),
		.need_ind(need_ind),
		.steps(steps),
		.a_field(a_field),
		.b_field(b_field)
	);

	pm_seq u_seq (
		.__clk(__clk),
		.rst_n(rst_n),
		.run(run),
		.cycle_end(cycle_end),
		.irq(irq),
		.need_arg(need_arg),
		.need_bmod(need_bmod),
		.need_ind(need_ind),
		.steps(steps),
		.state(state),
		.last_step(last_step),
		.mem_rd(mem_rd)
	);

	pm_strobe u_strobe (
		.__clk(__clk),
		.rst_n(rst_n),
		.cycle_end(cycle_end),
		.state(state),
		.last_step(last_step),
		.a_field(a_field),
		.b_field(b_field),
		.w_ir(w_ir),
		.w_ac(w_ac),
		.w_r(w_r),
		.w_ic(w_ic),
		.ic_inc(ic_inc),
		.reg_sel(reg_sel)
	);

endmodule

/* tb_clock.sv */
// testbench clock and reset source, instantiated once by tb_pm
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic __clk,
	output logic rst_n
);

	initial begin
		__clk = 1'b0;
		forever #(PERIOD / 2) __clk = ~__clk;
	end

	// released on a falling edge like the rest of the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge __clk);
		rst_n <= 1'b1;
	end

endmodule

/* tb_pm.sv */
// top testbench for pm_top: random instruction words and irq, reference model, per-test summary
`timescale 1ns/1ns

module tb_pm
	import pm_state_pkg::*, pm_instr_pkg::*;
();

	localparam int KC_TICKS = 3;
	localparam int PC_TICKS = 2;
	localparam int CYCLE_CLKS = KC_TICKS + PC_TICKS;
	localparam int N_INSTR = 200;
	// longest instruction is P1 P2 P3 P4, four P5 steps and PP
	localparam int LIMIT = (N_INSTR + 20) * 9 * CYCLE_CLKS + 200;

	logic __clk;
	logic rst_n;
	logic start_sw;
	logic stop_sw;
	logic hlt;
	logic irq;
	logic [WORD_W-1:0] rdt;
	logic run;
	pm_state_t state;
	logic cycle_end;
	logic mem_rd;
	logic w_ir;
	logic w_ac;
	logic w_r;
	logic w_ic;
	logic ic_inc;
	logic [REG_SEL_W-1:0] reg_sel;

	integer seed = 32'ha9ef;
	int errs [1:6] = '{default: 0};
	int phase = 1;
	int tick = 0;
	int clk_cnt = 0;
	int last_ce = 0;
	int rise_clk = 0;
	bit first_pending = 1'b0;
	bit run_prev = 1'b0;
	// expected front panel flags, updated where the DUT samples its inputs
	bit m_start = 1'b0;
	bit m_wait = 1'b0;
	bit m_run = 1'b0;
	bit start_prev = 1'b0;
	// model state and expectations for the next falling edge
	pm_state_t m_state = P0;
	pm_state_t ending;
	pm_state_t nxt;
	logic [15:0] m_word = '0;
	logic [15:0] m_ir = '0;
	logic [2:0] m_reg_sel = '0;
	logic [4:0] exp_strb = '0;
	int st_kind = 2;
	int m_left = 0;
	// event counters, model side and DUT side
	int n_done = 0;
	int cnt_p1 = 0;
	int cnt_p2 = 0;
	int cnt_p234 = 0;
	int cnt_p5 = 0;
	int cnt_pp = 0;
	int sum_steps = 0;
	int cnt_accept = 0;
	int cnt_wac = 0;
	int cnt_icinc = 0;
	int cnt_wr = 0;
	int cnt_wic = 0;
	int n_pass = 0;
	int n_fail = 0;
	int total = 0;
	int quiet_ce = 0;
	int target = 0;

	tb_clock #(.PERIOD(100), .RESET_CYCLES(2)) u_clk (.__clk(__clk), .rst_n(rst_n));

	pm_top #(.KC_TICKS(KC_TICKS), .PC_TICKS(PC_TICKS)) u_dut (
		.__clk(__clk), .rst_n(rst_n), .start_sw(start_sw), .stop_sw(stop_sw),
		.hlt(hlt), .irq(irq), .rdt(rdt), .run(run), .state(state),
		.cycle_end(cycle_end), .mem_rd(mem_rd), .w_ir(w_ir), .w_ac(w_ac),
		.w_r(w_r), .w_ic(w_ic), .ic_inc(ic_inc), .reg_sel(reg_sel)
	);

	// errors go to the running test, or to the behavior they belong to in the stream
	task automatic check_eq(input int kind, input int got, input int exp, input string what);
		int cat;
		cat = (phase == 1 || phase == 6) ? phase : kind;
		assert (got == exp) else begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errs[cat]++;
		end
	endtask

	// successor in the P1..P4 chain, C=0 argument, B!=0 modification, D indirect
	function automatic pm_state_t chain_from(input pm_state_t s, input logic [15:0] w);
		if (s == P1 && w[2:0] == 3'd0)
			return P2;
		if ((s == P1 || s == P2) && w[5:3] != 3'd0)
			return P3;
		if (s != P4 && w[9])
			return P4;
		return P5;
	endfunction

	task automatic wait_cycle_ends(input int n);
		repeat (n) begin
			@(negedge __clk);
			while (!cycle_end)
				@(negedge __clk);
		end
	endtask

	task automatic report(input int n, input string name);
		if (errs[n] == 0)
			n_pass++;
		else
			n_fail++;
		$display("test %0d, %s: %s, %0d errors", n, name,
			(errs[n] == 0) ? "ok" : "failed", errs[n]);
	endtask

	always @(negedge __clk) begin
		tick++;
		if (tick == LIMIT) begin
			$display("timeout: the run did not finish within %0d clocks", LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// START is set by a rising start_sw, WAIT by hlt at a cycle end, stop clears both
	always @(posedge __clk) begin
		if (rst_n) begin
			if (stop_sw) begin
				m_start = 1'b0;
				m_wait = 1'b0;
			end else begin
				if (start_sw && !start_prev)
					m_start = 1'b1;
				if (cycle_end && hlt)
					m_wait = 1'b1;
			end
			start_prev = start_sw;
			m_run = m_start && !m_wait;
		end
	end

	// reference model, one step per falling edge
	always @(negedge __clk) begin
		if (rst_n) begin
			clk_cnt++;
			check_eq(st_kind, state, m_state, "state");
			check_eq(2, w_ir, exp_strb[4], "w_ir");
			check_eq(3, w_ac, exp_strb[3], "w_ac");
			check_eq(4, w_r, exp_strb[2], "w_r");
			check_eq(5, w_ic, exp_strb[1], "w_ic");
			check_eq(2, ic_inc, exp_strb[0], "ic_inc");
			check_eq(3, reg_sel, m_reg_sel, "reg_sel");
			check_eq(2, mem_rd, (m_state == P1 || m_state == P2), "mem_rd");
			check_eq(6, run, m_run, "run");
			cnt_wac += w_ac;
			cnt_icinc += ic_inc;
			cnt_wr += w_r;
			cnt_wic += w_ic;
			if (m_run && !run_prev) begin
				rise_clk = clk_cnt;
				first_pending = 1'b1;
			end
			run_prev = m_run;
			exp_strb = '0;
			irq = (($random(seed) & 3) == 0);
			if (cycle_end) begin
				if (first_pending)
					check_eq(1, clk_cnt - rise_clk, KC_TICKS, "clocks from run to cycle_end");
				else
					check_eq(1, clk_cnt - last_ce, CYCLE_CLKS, "clocks between cycle_ends");
				first_pending = 1'b0;
				last_ce = clk_cnt;
				if (state == P5)
					cnt_p5++;
				if (state == PP)
					cnt_pp++;
				ending = m_state;
				nxt = P1;
				st_kind = 2;
				case (ending)
					P1: begin
						m_ir = m_word;
						exp_strb = 5'b10001;
						cnt_p1++;
						nxt = chain_from(P1, m_ir);
					end
					P2: begin
						exp_strb = 5'b01001;
						cnt_p2++;
						cnt_p234++;
						nxt = chain_from(P2, m_ir);
					end
					P3: begin
						exp_strb = 5'b01000;
						m_reg_sel = m_ir[5:3];
						cnt_p234++;
						nxt = chain_from(P3, m_ir);
					end
					P4: begin
						exp_strb = 5'b01000;
						cnt_p234++;
						nxt = P5;
					end
					P5: begin
						st_kind = 4;
						nxt = P5;
						if (m_left == 1) begin
							exp_strb = 5'b00100;
							m_reg_sel = m_ir[8:6];
							n_done++;
							st_kind = 5;
							cnt_accept += irq;
							nxt = irq ? PP : P1;
						end else begin
							m_left--;
						end
					end
					PP: begin
						exp_strb = 5'b00010;
						st_kind = 5;
					end
					default: nxt = P1;
				endcase
				if (!m_run)
					nxt = P0;
				if (nxt == P5 && ending != P5) begin
					m_left = int'(m_ir[11:10]) + 1;
					sum_steps += m_left;
				end
				// new word on rdt for the whole coming fetch
				if (nxt == P1) begin
					m_word = 16'($random(seed));
					rdt = m_word;
				end
				m_state = nxt;
			end
		end
	end

	initial begin
		start_sw = 1'b0;
		stop_sw = 1'b0;
		hlt = 1'b0;
		irq = 1'b0;
		rdt = '0;
		@(posedge rst_n);
		@(negedge __clk);
		check_eq(1, state, P0, "state after reset");
		check_eq(1, {run, cycle_end, mem_rd, reg_sel}, 0, "run, cycle_end, mem_rd, reg_sel");
		check_eq(1, {w_ir, w_ac, w_r, w_ic, ic_inc}, 0, "strobes after reset");
		start_sw = 1'b1;
		repeat (2) @(negedge __clk);
		start_sw = 1'b0;
		wait_cycle_ends(4);
		report(1, "reset and cycle timing");

		phase = 2;
		while (n_done < N_INSTR)
			@(negedge __clk);
		while (state != P1)
			@(negedge __clk);
		repeat (2) @(negedge __clk);
		check_eq(3, cnt_wac, cnt_p234, "w_ac pulses against P2/P3/P4 states");
		check_eq(3, cnt_icinc, cnt_p1 + cnt_p2, "ic_inc pulses");
		check_eq(4, cnt_p5, sum_steps, "P5 cycle_ends");
		check_eq(4, cnt_wr, n_done, "w_r pulses");
		check_eq(5, cnt_pp, cnt_accept, "PP states against accepted irq");
		check_eq(5, cnt_wic, cnt_accept, "w_ic pulses");
		report(2, "instruction state paths");
		report(3, "strobes per state");
		report(4, "execute length");
		report(5, "interrupt receive");

		phase = 6;
		hlt = 1'b1;
		while (run)
			@(negedge __clk);
		hlt = 1'b0;
		while (state != P0)
			@(negedge __clk);
		repeat (4 * CYCLE_CLKS) begin
			@(negedge __clk);
			quiet_ce += cycle_end;
		end
		check_eq(6, quiet_ce, 0, "cycle_ends while halted");
		stop_sw = 1'b1;
		@(negedge __clk);
		stop_sw = 1'b0;
		@(negedge __clk);
		start_sw = 1'b1;
		repeat (2) @(negedge __clk);
		start_sw = 1'b0;
		while (state == P0)
			@(negedge __clk);
		check_eq(6, state, P1, "state after restart");
		target = n_done + 3;
		while (n_done < target)
			@(negedge __clk);
		repeat (2) @(negedge __clk);
		report(6, "halt and restart");

		foreach (errs[i])
			total += errs[i];
		$display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, total);
		if (total == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
